//--- design/afu_output_top.sv
`timescale 1ns/10ps

module afu_output_top import oq_pkg::*; #(
  parameter int NUM_QUEUES      = 2,
  parameter int FIFO_DEPTH_BITS = 4,
  parameter int MEM_CREDITS     = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  conf_valid,
  input  oq_conf_t              conf,
  input  logic [NUM_QUEUES-1:0] user_valid,
  input  line_t                 user_line [NUM_QUEUES],
  output logic [NUM_QUEUES-1:0] user_ready,
  output logic                  mem_req_valid,
  output wr_req_t               mem_req,
  input  logic                  mem_credit,
  input  logic                  mem_ack_valid,
  input  qid_t                  mem_ack_tag,
  output logic [NUM_QUEUES-1:0] done,
  output logic [NUM_QUEUES-1:0] has_pending
);

  logic [NUM_QUEUES-1:0] q_req_valid;
  wr_req_t               q_req [NUM_QUEUES];
  logic [NUM_QUEUES-1:0] slot_open;

  for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
    output_queue_controller #(
      .QUEUE_ID        (i),
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
    ) u_output_queue_controller (
      .clk         (clk),
      .rst         (rst),
      .conf_valid  (conf_valid),
      .conf        (conf),
      .user_valid  (user_valid[i]),
      .user_line   (user_line[i]),
      .user_ready  (user_ready[i]),
      .slot_open   (slot_open[i]),
      .req_valid   (q_req_valid[i]),
      .req         (q_req[i]),
      .ack_valid   (mem_ack_valid),  // each queue filters acks by its own tag
      .ack_tag     (mem_ack_tag),
      .done        (done[i]),
      .has_pending (has_pending[i])
    );
  end

  write_arbiter #(
    .NUM_QUEUES  (NUM_QUEUES),
    .MEM_CREDITS (MEM_CREDITS)
  ) u_write_arbiter (
    .clk           (clk),
    .rst           (rst),
    .q_req_valid   (q_req_valid),
    .q_req         (q_req),
    .slot_open     (slot_open),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_credit    (mem_credit)
  );

endmodule

//--- design/oq_pkg.sv
package oq_pkg;

  typedef logic [63:0]  addr_t;  // cache-line address
  typedef logic [31:0]  qtd_t;   // line counts and pending counters
  typedef logic [15:0]  qid_t;   // queue id, doubles as the write tag
  typedef logic [511:0] line_t;  // one cache line

  // configuration word as driven by the host
  typedef struct packed {
    addr_t base;
    qtd_t  qtd;
    qid_t  qid;
  } oq_conf_t;

  // one write request towards memory
  typedef struct packed {
    line_t data;
    addr_t addr;
    qid_t  tag;
  } wr_req_t;

  typedef enum logic {
    ARB_IDLE,
    ARB_GRANT
  } arb_state_t;

endpackage

//--- design/output_queue_controller.sv
`timescale 1ns/10ps

module output_queue_controller import oq_pkg::*; #(
  parameter int QUEUE_ID        = 0,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     conf_valid,
  input  oq_conf_t conf,
  input  logic     user_valid,
  input  line_t    user_line,
  output logic     user_ready,
  input  logic     slot_open,
  output logic     req_valid,
  output wr_req_t  req,
  input  logic     ack_valid,
  input  qid_t     ack_tag,
  output logic     done,
  output logic     has_pending
);

  localparam qid_t MY_TAG = qid_t'(QUEUE_ID);

  oq_conf_t conf_reg;
  logic     conf_pend;
  logic     conf_hit;
  logic     configured;
  qtd_t     qtd;
  addr_t    addr_next;
  qtd_t     rd_cnt;
  qtd_t     req_cnt;
  qtd_t     pending;
  logic     fifo_re;
  logic     fifo_valid;
  line_t    fifo_dout;
  logic     fifo_empty;
  logic     fifo_almost_full;
  logic     fifo_almost_empty;
  logic     issue;
  logic     ack_hit;

  sync_fifo #(
    .WIDTH      ($bits(line_t)),
    .DEPTH_BITS (FIFO_DEPTH_BITS)
  ) u_fifo (
    .clk          (clk),
    .rst          (rst),
    .we           (user_valid),
    .din          (user_line),
    .re           (fifo_re),
    .valid        (fifo_valid),
    .dout         (fifo_dout),
    .count        (),
    .empty        (fifo_empty),
    .full         (),
    .almost_full  (fifo_almost_full),
    .almost_empty (fifo_almost_empty)
  );

  assign user_ready = !fifo_almost_full;  // keeps room for 4 lines in flight
  assign conf_hit   = conf_pend && (conf_reg.qid == MY_TAG);
  assign ack_hit    = ack_valid && (ack_tag == MY_TAG);

  // fifo_re is registered so empty lags a cycle, hence no back-to-back read near empty
  assign issue = configured && (rd_cnt < qtd) && slot_open && !fifo_empty &&
                 (!fifo_almost_empty || !fifo_re);

  assign done        = configured && (req_cnt == qtd) && (pending == '0);
  assign has_pending = (pending != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      conf_pend  <= 1'b0;
      configured <= 1'b0;
    end else begin
      conf_pend <= conf_valid;
      if (conf_hit) configured <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (conf_valid) conf_reg <= conf;  // id is compared a cycle later
    if (conf_hit) begin
      qtd       <= conf_reg.qtd;
      addr_next <= conf_reg.base;
    end else if (fifo_valid) begin
      addr_next <= addr_next + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fifo_re <= 1'b0;
      rd_cnt  <= '0;
    end else begin
      fifo_re <= issue;
      if (issue) rd_cnt <= rd_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
      req_cnt   <= '0;
      pending   <= '0;
    end else begin
      req_valid <= fifo_valid;
      if (req_valid) req_cnt <= req_cnt + 1'b1;
      case ({req_valid, ack_hit})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;  // both or neither leave it unchanged
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_valid) req <= '{data: fifo_dout, addr: addr_next, tag: MY_TAG};
  end

endmodule

//--- design/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
  parameter int WIDTH      = 512,
  parameter int DEPTH_BITS = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [WIDTH-1:0]      din,
  input  logic                  re,
  output logic                  valid,
  output logic [WIDTH-1:0]      dout,
  output logic [DEPTH_BITS:0]   count,
  output logic                  empty,
  output logic                  full,
  output logic                  almost_full,
  output logic                  almost_empty
);

  localparam int DEPTH = 2 ** DEPTH_BITS;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = we && !full;  // a push into a full buffer is dropped
  assign do_rd = re && !empty;

  assign empty        = (count == '0);
  assign full         = (count == (DEPTH_BITS + 1)'(DEPTH));
  assign almost_full  = (count >= (DEPTH_BITS + 1)'(DEPTH - 4));
  assign almost_empty = (count <= (DEPTH_BITS + 1)'(2));

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= do_rd;
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
    if (do_rd) dout <= mem[rd_ptr];  // registered output
  end

endmodule

//--- design/write_arbiter.sv
`timescale 1ns/10ps

module write_arbiter import oq_pkg::*; #(
  parameter int NUM_QUEUES  = 2,
  parameter int MEM_CREDITS = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [NUM_QUEUES-1:0] q_req_valid,
  input  wr_req_t               q_req [NUM_QUEUES],
  output logic [NUM_QUEUES-1:0] slot_open,
  output logic                  mem_req_valid,
  output wr_req_t               mem_req,
  input  logic                  mem_credit
);

  localparam int CW    = $clog2(MEM_CREDITS + 1) + 1;
  localparam int PW    = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
  localparam int DELAY = 3;  // grant to controller request, in cycles

  arb_state_t      state;
  logic [PW-1:0]   ptr;
  logic [CW-1:0]   credit_cnt;
  logic [CW-1:0]   reserved;
  logic [DELAY-1:0] grant_pipe;
  logic            can_grant;
  logic            grant;
  logic            spend;
  wr_req_t         sel_req;

  // grants still on their way count against the credits
  always_comb begin
    reserved = '0;
    for (int i = 0; i < DELAY; i++) reserved = reserved + CW'(grant_pipe[i]);
  end

  assign can_grant = (credit_cnt > reserved);
  assign grant     = (state == ARB_GRANT) && can_grant;
  assign spend     = |q_req_valid;

  always_comb begin
    slot_open = '0;
    if (grant) slot_open[ptr] = 1'b1;
  end

  always_comb begin
    sel_req = '0;
    for (int i = 0; i < NUM_QUEUES; i++) begin
      if (q_req_valid[i]) sel_req = q_req[i];  // only the granted queue can be valid
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= ARB_IDLE;
      ptr           <= '0;
      credit_cnt    <= CW'(MEM_CREDITS);
      grant_pipe    <= '0;
      mem_req_valid <= 1'b0;
    end else begin
      state         <= can_grant ? ARB_GRANT : ARB_IDLE;
      grant_pipe    <= {grant_pipe[DELAY-2:0], grant};
      mem_req_valid <= spend;
      if (grant) ptr <= (ptr == PW'(NUM_QUEUES - 1)) ? '0 : ptr + 1'b1;
      case ({mem_credit, spend})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (spend) mem_req <= sel_req;
  end

endmodule

//--- files.f
design/oq_pkg.sv
design/sync_fifo.sv
design/output_queue_controller.sv
design/write_arbiter.sv
design/afu_output_top.sv
tests/tb_clock.sv
tests/afu_output_assert.sv
tests/tb_top.sv

//--- tests/afu_output_assert.sv
`timescale 1ns/10ps

module afu_output_assert #(
  parameter int NUM_QUEUES  = 2,
  parameter int MEM_CREDITS = 4
) (
  input logic                  clk,
  input logic                  rst,
  input logic [NUM_QUEUES-1:0] user_valid,
  input logic [NUM_QUEUES-1:0] user_ready,
  input logic                  mem_req_valid,
  input logic                  mem_credit,
  input logic [NUM_QUEUES-1:0] done,
  input logic [NUM_QUEUES-1:0] has_pending
);

  int in_flight;
  int fail_count = 0;  // failed assertions so far

  always_ff @(posedge clk) begin
    if (rst) in_flight <= 0;
    else in_flight <= in_flight + int'(mem_req_valid) - int'(mem_credit);
  end

  // outputs are quiet in the cycle after a reset cycle
  assert property (@(posedge clk) rst |=> (!mem_req_valid && done == '0 &&
                                           has_pending == '0 && user_ready == '1))
    else begin
      $error("outputs not idle after reset");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) (user_valid & ~user_ready) == '0)
    else begin
      $error("line pushed while the buffer was not ready");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) in_flight <= MEM_CREDITS)
    else begin
      $error("more requests in flight than memory credits");
      fail_count++;
    end

endmodule

bind afu_output_top afu_output_assert #(
  .NUM_QUEUES  (NUM_QUEUES),
  .MEM_CREDITS (MEM_CREDITS)
) u_afu_output_assert (.*);

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/10ps

module tb_top import oq_pkg::*; ();

  localparam int          NUM_QUEUES  = 2;
  localparam int          MEM_CREDITS = 4;
  localparam int          LINES [NUM_QUEUES] = '{20, 12};
  localparam addr_t       BASE [NUM_QUEUES] = '{64'h1000, 64'h8000};
  localparam int          MAX_CYCLES = (LINES[0] + LINES[1]) * 125;  // ample for 8-cycle delays
  localparam logic [31:0] SEED = 32'h78933d51;

  logic                  clk, rst, conf_valid, mem_credit, mem_ack_valid, mem_req_valid;
  oq_conf_t              conf;
  logic [NUM_QUEUES-1:0] user_valid, user_ready, done, has_pending;
  line_t                 user_line [NUM_QUEUES];
  wr_req_t               mem_req;
  qid_t                  mem_ack_tag;

  int                    req_seen [NUM_QUEUES] = '{default: 0};  // requests seen for each tag
  int                    ack_seen [NUM_QUEUES] = '{default: 0};
  logic [NUM_QUEUES-1:0] done_seen = '0;
  int                    due_q [$];
  qid_t                  tag_q [$];
  int                    resp_cycle = 0;
  int                    run_cycles = 0;
  logic [31:0]           stim_lfsr = SEED;
  logic [31:0]           resp_lfsr = SEED;  // the responder steps its own copy

  tb_clock u_tb_clock (.clk(clk), .rst(rst));

  afu_output_top #(
    .NUM_QUEUES      (NUM_QUEUES),
    .FIFO_DEPTH_BITS (4),
    .MEM_CREDITS     (MEM_CREDITS)
  ) u_afu_output_top (.*);

  function automatic int take_bits(inout logic [31:0] state, input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(state[0]);
      state = state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
    end
    return val;
  endfunction

  // every 32-bit word holds queue, line index and word index
  function automatic line_t make_line(input int q, input int k);
    line_t line;
    for (int j = 0; j < 16; j++) line[j*32 +: 32] = {8'(q), 8'(k), 8'(j), 8'ha5};
    return line;
  endfunction

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic value_error(input string msg);
    $display("error at time %0t: %s", $time, msg);
    stop_run();
  endtask

  task automatic send_conf(input int qid, input int count, input addr_t addr);
    @(posedge clk);
    conf_valid <= 1'b1;
    conf       <= '{base: addr, qtd: qtd_t'(count), qid: qid_t'(qid)};
    @(posedge clk);
    conf_valid <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  initial begin
    int gap [NUM_QUEUES];
    int pushed [NUM_QUEUES];
    gap           = '{default: 0};
    pushed        = '{default: 0};
    conf_valid    = 1'b0;
    conf          = '0;
    user_valid    = '0;
    user_line     = '{default: '0};
    mem_credit    = 1'b0;
    mem_ack_valid = 1'b0;
    mem_ack_tag   = '0;
    do @(posedge clk); while (rst);
    repeat (3) @(posedge clk);
    send_conf(0, LINES[0], BASE[0]);
    send_conf(1, LINES[1], BASE[1]);
    send_conf(7, 5, 64'hf000);  // no controller owns id 7
    while (pushed[0] < LINES[0] || pushed[1] < LINES[1]) begin
      @(posedge clk);
      for (int q = 0; q < NUM_QUEUES; q++) begin
        if (gap[q] > 0) begin
          gap[q]--;
          user_valid[q] <= 1'b0;
        end else if (pushed[q] < LINES[q] && !user_valid[q] && user_ready[q]) begin
          user_valid[q] <= 1'b1;
          user_line[q]  <= make_line(q, pushed[q]);
          pushed[q]++;
          gap[q] = take_bits(stim_lfsr, 2);
        end else begin
          user_valid[q] <= 1'b0;
        end
      end
    end
    @(posedge clk);
    user_valid <= '0;
    while (done != '1) @(posedge clk);
    repeat (20) @(posedge clk);  // done must hold and nothing more may arrive
    @(negedge clk);
    if (u_afu_output_top.u_afu_output_assert.fail_count != 0) begin
      $display("an assertion on the DUT ports failed");
      stop_run();
    end else if (done == '1 && req_seen[0] == LINES[0] && req_seen[1] == LINES[1] &&
        ack_seen[0] == LINES[0] && ack_seen[1] == LINES[1] && due_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else value_error("totals at the end do not match the configured line counts");
  end

  // memory responder and scoreboard
  always @(posedge clk) begin : responder
    int q;
    int outstanding;
    int due;
    mem_credit    <= 1'b0;
    mem_ack_valid <= 1'b0;
    if (!rst) begin
      resp_cycle++;
      for (int i = 0; i < NUM_QUEUES; i++) begin
        outstanding = req_seen[i] - ack_seen[i];
        if (done[i]) begin
          assert (ack_seen[i] == LINES[i] && req_seen[i] == LINES[i])
            else value_error($sformatf("done[%0d] high after %0d acks", i, ack_seen[i]));
          done_seen[i] = 1'b1;
        end
        assert (done[i] || !done_seen[i]) else value_error($sformatf("done[%0d] fell", i));
        assert (has_pending[i] || outstanding == 0)
          else value_error($sformatf("has_pending[%0d] low with writes in flight", i));
        assert (!has_pending[i] || outstanding > 0 || (mem_req_valid && mem_req.tag == i))
          else value_error($sformatf("has_pending[%0d] high with nothing in flight", i));
      end
      if (mem_ack_valid) ack_seen[mem_ack_tag]++;
      if (mem_req_valid) begin
        assert (mem_req.tag < NUM_QUEUES)
          else value_error($sformatf("request with tag %0d", mem_req.tag));
        q = int'(mem_req.tag);
        assert (mem_req.addr == BASE[q] + addr_t'(req_seen[q]))
          else value_error($sformatf("queue %0d line %0d addr %0h", q, req_seen[q], mem_req.addr));
        assert (mem_req.data == make_line(q, req_seen[q]))
          else value_error($sformatf("queue %0d line %0d carries wrong data", q, req_seen[q]));
        req_seen[q]++;
        due = resp_cycle + 1 + take_bits(resp_lfsr, 3);
        if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1;  // one answer per cycle
        due_q.push_back(due);
        tag_q.push_back(mem_req.tag);
      end
      if (due_q.size() > 0 && due_q[0] <= resp_cycle) begin
        mem_credit    <= 1'b1;
        mem_ack_valid <= 1'b1;
        mem_ack_tag   <= tag_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin : watchdog
    run_cycles++;
    if (u_afu_output_top.u_afu_output_assert.fail_count != 0) begin
      $display("an assertion on the DUT ports failed");
      stop_run();
    end else if (run_cycles >= MAX_CYCLES) begin
      $display("timeout: queues not done after %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

endmodule
